//--- zx_pkg.sv
package zx_pkg;

	// visible screen area
	localparam int h_area = 256;
	localparam int v_area = 192;

	typedef enum logic {
		mode_pent = 1'b0,
		mode_128  = 1'b1
	} raster_mode_e;

	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;

	// per-mode raster constants, index 0 is pentagon and index 1 is 128
	localparam logic [8:0] h_total [2]       = '{9'd448, 9'd456};
	localparam logic [8:0] v_total [2]       = '{9'd320, 9'd311};
	localparam logic [8:0] h_sync_start [2]  = '{9'd328, 9'd340};
	localparam logic [8:0] h_sync_len [2]    = '{9'd33, 9'd33};
	localparam logic [8:0] h_blank_start [2] = '{9'd320, 9'd312};
	localparam logic [8:0] h_blank_end [2]   = '{9'd384, 9'd416};
	localparam logic [8:0] v_sync_start [2]  = '{9'd248, 9'd248};
	localparam logic [8:0] v_sync_len [2]    = '{9'd8, 9'd8};

	// frame interrupt window
	localparam logic [8:0] int_line [2]   = '{9'd239, 9'd248};
	localparam logic [8:0] int_h_from [2] = '{9'd318, 9'd5};
	localparam logic [8:0] int_h_to [2]   = '{9'd384, 9'd64};

	typedef struct packed {
		logic [15:0] addr;
		logic        n_mreq;
		logic        n_iorq;
		logic        n_rd;
		logic        n_wr;
		logic        n_m1;
		logic        n_rfsh;
	} cpu_bus_t;

	// the same cpu byte seen as port #fe or as port #7ffd
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [2:0] unused;
			logic       beeper;
			logic       tape_out;
			logic [2:0] border;
		} fe;
		struct packed {
			logic [1:0] unused;
			logic       lock;
			logic       rom_bank;
			logic       screen_bank;
			logic [2:0] ram_bank;
		} p7ffd;
	} cpu_wdata_u;

	typedef struct packed {
		logic [2:0] ram_bank;
		logic       screen_bank;
		logic       rom_bank;
		logic       lock;
	} paging_t;

	typedef struct packed {
		logic i;
		logic g;
		logic r;
		logic b;
	} rgbi_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic csync;
	} video_sync_t;

	typedef struct packed {
		hcount_t hc;
		vcount_t vc;
		logic    blank;
	} raster_t;

endpackage

//--- raster_timing.sv
module raster_timing import zx_pkg::*; (
	input  logic         clk7,
	input  logic         rst_n,
	input  raster_mode_e mode,
	output raster_t      raster,
	output video_sync_t  sync,
	output logic         n_int
);

	hcount_t hc;
	vcount_t vc;
	logic    hc_wrap;
	logic    vc_wrap;
	logic    hsync_next;
	logic    vsync_next;
	logic    int_next;

	// >= so a mode switch mid-frame cannot run a counter past the new end
	assign hc_wrap = hc >= h_total[mode] - 9'd1;
	assign vc_wrap = vc >= v_total[mode] - 9'd1;

	assign hsync_next = (hc >= h_sync_start[mode]) &&
		(hc < h_sync_start[mode] + h_sync_len[mode]);
	assign vsync_next = (vc >= v_sync_start[mode]) &&
		(vc < v_sync_start[mode] + v_sync_len[mode]);
	assign int_next = (vc == int_line[mode]) &&
		(hc >= int_h_from[mode]) && (hc < int_h_to[mode]);

	assign raster.hc = hc;
	assign raster.vc = vc;
	// blank covers the whole vsync lines as well
	assign raster.blank = vsync_next ||
		((hc >= h_blank_start[mode]) && (hc < h_blank_end[mode]));

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			hc <= '0;
			vc <= '0;
		end else if (hc_wrap) begin
			hc <= '0;
			if (vc_wrap) begin
				vc <= '0;
			end else begin
				vc <= vc + 9'd1;
			end
		end else begin
			hc <= hc + 9'd1;
		end
	end

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			sync.hsync <= 1'b0;
			sync.vsync <= 1'b0;
			sync.csync <= 1'b1;
			n_int <= 1'b1;
		end else begin
			sync.hsync <= hsync_next;
			sync.vsync <= vsync_next;
			sync.csync <= ~(hsync_next ^ vsync_next);
			n_int <= ~int_next;
		end
	end

	// hc may only overshoot in the cycle the mode changes
	assert property (@(posedge clk7) disable iff (!rst_n)
		mode == $past(mode) |-> hc < h_total[mode]);

endmodule

//--- screen_fetch.sv
module screen_fetch import zx_pkg::*; #(
	// pipeline below works for delays of 8 to 10
	parameter int screen_delay = 8
) (
	input  logic        clk7,
	input  logic        rst_n,
	input  raster_t     raster,
	input  logic        n_int,
	input  cpu_bus_t    cpu,
	input  logic [2:0]  border,
	input  logic [7:0]  vram_rdata,
	output logic        screen_read,
	output logic [14:0] screen_addr,
	output rgbi_t       rgbi
);

	logic        bus_idle;
	logic        screen_load;
	logic        attr_sel;
	logic [14:0] bitmap_addr;
	logic [14:0] attr_addr;
	hcount_t     load_hc;
	hcount_t     pix_hc;
	logic        in_lines;
	logic        cell_load;
	logic        screen_show;
	logic [7:0]  bitmap_next;
	logic [7:0]  attr_next;
	logic [7:0]  bitmap;
	logic [7:0]  attr;
	logic        n_int_q;
	logic [4:0]  flash_cnt;
	logic        pixel;
	logic [2:0]  colour;

	// refresh cycles leave the bus free
	assign bus_idle = (cpu.n_mreq || !cpu.n_rfsh) && cpu.n_iorq;
	assign in_lines = raster.vc < v_area;
	assign screen_load = in_lines && (raster.hc < h_area);
	assign screen_read = screen_load && bus_idle;

	// interleaved spectrum bitmap layout, attributes from #5800
	assign bitmap_addr = {2'b10, raster.vc[7:6], raster.vc[2:0], raster.vc[5:3], raster.hc[7:3]};
	assign attr_addr = {5'b10110, raster.vc[7:3], raster.hc[7:3]};
	assign screen_addr = attr_sel ? attr_addr : bitmap_addr;

	// cell loads two cycles ahead of its first pixel: one for the shifter, one for rgbi
	assign load_hc = raster.hc - hcount_t'(screen_delay - 2);
	assign pix_hc = raster.hc - hcount_t'(screen_delay - 1);
	assign cell_load = in_lines && (load_hc < h_area) && (load_hc[2:0] == 3'd0);
	assign screen_show = in_lines && (pix_hc < h_area);

	assign pixel = bitmap[7] ^ (attr[7] & flash_cnt[4]);
	assign colour = pixel ? attr[2:0] : attr[5:3];

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			attr_sel <= 1'b0;
			n_int_q <= 1'b1;
			flash_cnt <= '0;
		end else begin
			if (screen_read) begin
				attr_sel <= ~attr_sel;
			end
			n_int_q <= n_int;
			// flash advances once per frame
			if (n_int_q && !n_int) begin
				flash_cnt <= flash_cnt + 5'd1;
			end
		end
	end

	always_ff @(posedge clk7) begin
		if (screen_read) begin
			if (attr_sel) begin
				attr_next <= vram_rdata;
			end else begin
				bitmap_next <= vram_rdata;
			end
		end
		if (cell_load) begin
			bitmap <= bitmap_next;
			attr <= attr_next;
		end else begin
			bitmap <= {bitmap[6:0], 1'b0};
		end
	end

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			rgbi <= '0;
		end else if (raster.blank) begin
			rgbi <= '0;
		end else if (screen_show) begin
			rgbi <= '{i: attr[6] & (|colour), g: colour[2], r: colour[1], b: colour[0]};
		end else begin
			rgbi <= '{i: 1'b0, g: border[2], r: border[1], b: border[0]};
		end
	end

	// a cpu memory cycle keeps the address bus
	assert property (@(posedge clk7) disable iff (!rst_n)
		!(screen_read && !cpu.n_mreq && cpu.n_rfsh));

endmodule

//--- io_ports.sv
module io_ports import zx_pkg::*; (
	input  logic       clk7,
	input  logic       rst_n,
	input  cpu_bus_t   cpu,
	input  cpu_wdata_u cpu_wdata,
	input  logic [4:0] kd,
	input  logic       tape_in,
	output logic [7:0] cpu_rdata,
	output logic       cpu_rdata_en,
	output logic [2:0] border,
	output logic       beeper,
	output logic       tape_out,
	output paging_t    paging
);

	logic io_req;
	logic fe_cs;
	logic p7ffd_cs;
	logic fe_rd;
	logic tape_bit;

	// interrupt acknowledge also drives iorq, with m1 low
	assign io_req = !cpu.n_iorq && cpu.n_m1;
	assign fe_cs = io_req && !cpu.addr[0];
	assign p7ffd_cs = io_req && !cpu.addr[1] && !cpu.addr[15] &&
		(cpu.addr[14] || cpu.addr[13]);
	assign fe_rd = fe_cs && !cpu.n_rd;

	assign tape_out = tape_bit ^ tape_in;

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			border <= '0;
			beeper <= 1'b0;
			tape_bit <= 1'b0;
			paging <= '0;
			cpu_rdata <= '0;
			cpu_rdata_en <= 1'b0;
		end else begin
			if (fe_cs && !cpu.n_wr) begin
				border <= cpu_wdata.fe.border;
				beeper <= cpu_wdata.fe.beeper;
				tape_bit <= cpu_wdata.fe.tape_out;
			end
			// once locked only reset reopens paging
			if (p7ffd_cs && !cpu.n_wr && !paging.lock) begin
				paging <= '{
					ram_bank: cpu_wdata.p7ffd.ram_bank,
					screen_bank: cpu_wdata.p7ffd.screen_bank,
					rom_bank: cpu_wdata.p7ffd.rom_bank,
					lock: cpu_wdata.p7ffd.lock
				};
			end
			cpu_rdata_en <= fe_rd;
			cpu_rdata <= fe_rd ? {1'b1, tape_in, 1'b1, kd} : 8'hff;
		end
	end

endmodule

//--- mem_map.sv
module mem_map import zx_pkg::*; (
	input  logic        clk7,
	input  logic        rst_n,
	input  cpu_bus_t    cpu,
	input  paging_t     paging,
	input  logic        screen_read,
	input  logic [14:0] screen_addr,
	output logic [18:0] va,
	output logic        n_vrd,
	output logic        n_vwr,
	output logic        n_romcs,
	output logic [2:0]  ra
);

	logic       mem_req;
	logic       rom_area;
	logic       n_romcs_q;
	logic       n_ramcs_q;
	logic [2:0] bank;
	logic [3:0] ram_a;

	assign mem_req = !cpu.n_mreq && cpu.n_rfsh;
	assign rom_area = cpu.addr[15:14] == 2'b00;

	// the rom quarter falls into default too, its bank is never used
	always_comb begin
		case (cpu.addr[15:14])
			2'b01: bank = 3'd5;
			2'b10: bank = 3'd2;
			default: bank = paging.ram_bank;
		endcase
	end

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			n_romcs_q <= 1'b1;
			n_ramcs_q <= 1'b1;
			ram_a <= '0;
		end else begin
			n_romcs_q <= !(mem_req && rom_area);
			n_ramcs_q <= !(mem_req && !rom_area);
			// bank bits go out as {b1, b2, b0} so banks 5 and 7 sit at x11
			if (mem_req) begin
				ram_a <= {bank[1], bank[2], bank[0], cpu.addr[13]};
			end
		end
	end

	assign n_romcs = n_romcs_q | cpu.n_mreq;
	assign n_vrd = (n_ramcs_q | cpu.n_rd) & ~screen_read;
	assign n_vwr = n_ramcs_q | cpu.n_wr | screen_read;
	assign ra = {2'b00, paging.rom_bank};

	// screen bank 0 lands on bank 5, bank 1 on bank 7
	assign va = screen_read ? {2'b11, paging.screen_bank, 1'b1, screen_addr} :
		{2'b11, ram_a, cpu.addr[12:0]};

endmodule

//--- zx_ula.sv
module zx_ula import zx_pkg::*; (
	input  logic         clk7,
	input  logic         rst_n,
	input  raster_mode_e mode,
	input  cpu_bus_t     cpu,
	input  cpu_wdata_u   cpu_wdata,
	input  logic [4:0]   kd,
	input  logic         tape_in,
	input  logic [7:0]   vram_rdata,
	output logic [7:0]   cpu_rdata,
	output logic         cpu_rdata_en,
	output rgbi_t        rgbi,
	output video_sync_t  sync,
	output logic         n_int,
	output logic [18:0]  va,
	output logic         n_vrd,
	output logic         n_vwr,
	output logic         n_romcs,
	output logic [2:0]   ra,
	output logic         beeper,
	output logic         tape_out
);

	raster_t     raster;
	logic [2:0]  border;
	paging_t     paging;
	logic        screen_read;
	logic [14:0] screen_addr;

	raster_timing i_raster_timing (
		.clk7   (clk7),
		.rst_n  (rst_n),
		.mode   (mode),
		.raster (raster),
		.sync   (sync),
		.n_int  (n_int)
	);

	screen_fetch #(
		.screen_delay (8)
	) i_screen_fetch (
		.clk7        (clk7),
		.rst_n       (rst_n),
		.raster      (raster),
		.n_int       (n_int),
		.cpu         (cpu),
		.border      (border),
		.vram_rdata  (vram_rdata),
		.screen_read (screen_read),
		.screen_addr (screen_addr),
		.rgbi        (rgbi)
	);

	io_ports i_io_ports (
		.clk7         (clk7),
		.rst_n        (rst_n),
		.cpu          (cpu),
		.cpu_wdata    (cpu_wdata),
		.kd           (kd),
		.tape_in      (tape_in),
		.cpu_rdata    (cpu_rdata),
		.cpu_rdata_en (cpu_rdata_en),
		.border       (border),
		.beeper       (beeper),
		.tape_out     (tape_out),
		.paging       (paging)
	);

	mem_map i_mem_map (
		.clk7        (clk7),
		.rst_n       (rst_n),
		.cpu         (cpu),
		.paging      (paging),
		.screen_read (screen_read),
		.screen_addr (screen_addr),
		.va          (va),
		.n_vrd       (n_vrd),
		.n_vwr       (n_vwr),
		.n_romcs     (n_romcs),
		.ra          (ra)
	);

endmodule

//--- tb_zx_ula.sv
module tb_zx_ula import zx_pkg::*; ();

	localparam int clk_period = 10;
	localparam int num_tests = 5;
	// 256 pixels on each of the 192 screen lines
	localparam int screen_cycles = 256 * 192;
	// three frames of the 128 raster for every test
	localparam int watchdog_time = num_tests * 3 * 456 * 311 * clk_period;

	// attribute #2b is paper 5 with ink 3, border 6 comes from port #fe
	localparam rgbi_t ink_colour = '{i: 1'b0, g: 1'b0, r: 1'b1, b: 1'b1};
	localparam rgbi_t paper_colour = '{i: 1'b0, g: 1'b1, r: 1'b0, b: 1'b1};
	localparam rgbi_t border_6 = '{i: 1'b0, g: 1'b1, r: 1'b1, b: 1'b0};
	localparam rgbi_t black = '{i: 1'b0, g: 1'b0, r: 1'b0, b: 1'b0};

	logic         clk7;
	logic         rst_n;
	raster_mode_e mode;
	cpu_bus_t     cpu;
	cpu_wdata_u   cpu_wdata;
	logic [4:0]   kd;
	logic         tape_in;
	logic [7:0]   vram_rdata;
	logic [7:0]   cpu_rdata;
	logic         cpu_rdata_en;
	rgbi_t        rgbi;
	video_sync_t  sync;
	logic         n_int;
	logic [18:0]  va;
	logic         n_vrd;
	logic         n_vwr;
	logic         n_romcs;
	logic [2:0]   ra;
	logic         beeper;
	logic         tape_out;

	logic [7:0] vram [0:524287];
	integer     seed;
	int         value_errors = 0;
	int         other_errors = 0;

	zx_ula i_zx_ula (
		.clk7         (clk7),
		.rst_n        (rst_n),
		.mode         (mode),
		.cpu          (cpu),
		.cpu_wdata    (cpu_wdata),
		.kd           (kd),
		.tape_in      (tape_in),
		.vram_rdata   (vram_rdata),
		.cpu_rdata    (cpu_rdata),
		.cpu_rdata_en (cpu_rdata_en),
		.rgbi         (rgbi),
		.sync         (sync),
		.n_int        (n_int),
		.va           (va),
		.n_vrd        (n_vrd),
		.n_vwr        (n_vwr),
		.n_romcs      (n_romcs),
		.ra           (ra),
		.beeper       (beeper),
		.tape_out     (tape_out)
	);

	// video ram answers the address at once
	assign vram_rdata = vram[va];

	initial begin
		clk7 = 1'b0;
		forever #(clk_period / 2) clk7 = ~clk7;
	end

	function automatic int frame_len(input raster_mode_e m);
		// 448 x 320 for pentagon, 456 x 311 for 128
		return (m == mode_pent) ? 143360 : 141816;
	endfunction

	function automatic int line_len(input raster_mode_e m);
		return (m == mode_pent) ? 448 : 456;
	endfunction

	function automatic int int_width(input raster_mode_e m);
		return (m == mode_pent) ? 66 : 59;
	endfunction

	function automatic cpu_bus_t bus_cycle(input logic [15:0] address, input logic mreq_n,
			input logic iorq_n, input logic rd_n, input logic wr_n);
		return '{addr: address, n_mreq: mreq_n, n_iorq: iorq_n, n_rd: rd_n, n_wr: wr_n,
			n_m1: 1'b1, n_rfsh: 1'b1};
	endfunction

	// bank bits leave as {b1, b2, b0}, so the screen banks 5 and 7 sit at x11
	function automatic logic [18:0] bank_va(input logic [2:0] bank, input logic [15:0] address);
		return {2'b11, bank[1], bank[2], bank[0], address[13:0]};
	endfunction

	// 1 is hsync, 2 is vsync, anything else the active low interrupt
	function automatic logic pulse_level(input int which);
		return (which == 1) ? sync.hsync : (which == 2) ? sync.vsync : !n_int;
	endfunction

	task automatic print_counts();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
	endtask

	task automatic report_fault(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		other_errors++;
	endtask

	task automatic check_rgbi(input string name, input rgbi_t got, input rgbi_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_addr(input string name, input logic [18:0] got, input logic [18:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic fill_ram_random();
		for (int i = 0; i < 524288; i++) begin
			vram[i] = 8'($random(seed));
		end
	endtask

	// screen bank 0 is ram bank 5: bitmap from #4000, attributes from #5800
	task automatic fill_screen(input logic [7:0] bitmap_byte, input logic [7:0] attr_byte);
		for (logic [15:0] a = 16'h4000; a < 16'h5b00; a++) begin
			vram[bank_va(3'd5, a)] = (a < 16'h5800) ? bitmap_byte : attr_byte;
		end
	endtask

	task automatic io_write(input logic [15:0] address, input logic [7:0] data);
		@(posedge clk7);
		cpu <= bus_cycle(address, 1'b1, 1'b0, 1'b1, 1'b0);
		cpu_wdata <= data;
		@(posedge clk7);
		cpu <= bus_cycle(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1);
	endtask

	task automatic io_read(input logic [15:0] address, output logic [7:0] data);
		int n;
		@(posedge clk7);
		cpu <= bus_cycle(address, 1'b1, 1'b0, 1'b0, 1'b1);
		@(posedge clk7);
		cpu <= bus_cycle(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1);
		n = 0;
		do begin
			@(posedge clk7);
			n++;
		end while (!cpu_rdata_en && n < 4);
		if (!cpu_rdata_en) begin
			report_fault("no valid read data after an io read");
		end
		data = cpu_rdata;
	endtask

	task automatic mem_access(input logic [15:0] address, input logic write,
			output logic [18:0] va_seen, output logic n_romcs_seen,
			output logic n_vrd_seen, output logic n_vwr_seen);
		@(posedge clk7);
		cpu <= bus_cycle(address, 1'b0, 1'b1, write, !write);
		// selects and bank are registered, sample in the second cycle
		repeat (2) @(posedge clk7);
		va_seen = va;
		n_romcs_seen = n_romcs;
		n_vrd_seen = n_vrd;
		n_vwr_seen = n_vwr;
		cpu <= bus_cycle(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1);
	endtask

	task automatic wait_int_fall();
		logic prev;
		logic done;
		int n;
		prev = 1'b0;
		done = 1'b0;
		n = 0;
		while (!done && n < 2 * frame_len(mode)) begin
			@(posedge clk7);
			done = prev && !n_int;
			prev = n_int;
			n++;
		end
		if (!done) begin
			report_fault("no frame interrupt seen");
		end
	endtask

	// finds the start of a pulse, then times its width and the gap to the next start
	task automatic measure_pulse(input string what, input int which, input int limit,
			output int period, output int width);
		logic prev;
		logic cur;
		logic found;
		int n;
		prev = 1'b1;
		found = 1'b0;
		n = 0;
		period = 0;
		width = 1;
		while (!found && n < limit) begin
			@(posedge clk7);
			cur = pulse_level(which);
			found = cur && !prev;
			prev = cur;
			n++;
		end
		if (!found) begin
			report_fault({"no ", what, " pulse seen"});
			return;
		end
		found = 1'b0;
		while (!found && period < limit) begin
			@(posedge clk7);
			period++;
			cur = pulse_level(which);
			if (cur && !prev) begin
				found = 1'b1;
			end else if (cur) begin
				width++;
			end
			prev = cur;
		end
		if (!found) begin
			report_fault({"second ", what, " pulse missing"});
		end
	endtask

	// one frame period covers every raster position once
	task automatic measure_colours(input rgbi_t screen_col, input rgbi_t border_col,
			output int n_screen, output int n_border, output int n_zero, output int n_other);
		n_screen = 0;
		n_border = 0;
		n_zero = 0;
		n_other = 0;
		repeat (frame_len(mode)) begin
			@(posedge clk7);
			if (rgbi == screen_col) begin
				n_screen++;
			end else if (rgbi == border_col) begin
				n_border++;
			end else if (rgbi == black) begin
				n_zero++;
			end else begin
				n_other++;
			end
		end
	endtask

	task automatic test_timing(input raster_mode_e m);
		int period;
		int width;
		@(posedge clk7);
		mode <= m;
		// let the counters leave the line in which the mode changed
		repeat (2 * line_len(m)) @(posedge clk7);
		measure_pulse("hsync", 1, 2 * line_len(m), period, width);
		check_count("hsync period", period, line_len(m));
		measure_pulse("n_int", 0, 2 * frame_len(m), period, width);
		check_count("n_int period", period, frame_len(m));
		check_count("n_int low width", width, int_width(m));
		// vsync lasts 8 whole lines and starts outside hsync
		measure_pulse("vsync", 2, 2 * frame_len(m), period, width);
		check_count("vsync period", period, frame_len(m));
		check_count("vsync width", width, 8 * line_len(m));
		check_bit("csync at vsync start", sync.csync, 1'b0);
	endtask

	task automatic test_screen_pixels();
		int n_screen;
		int n_border;
		int n_zero;
		int n_other;
		fill_screen(8'hff, 8'h2b);
		// the interrupt line lies below the screen, so no stale cell is shown
		wait_int_fall();
		measure_colours(ink_colour, black, n_screen, n_border, n_zero, n_other);
		check_count("ink cycles", n_screen, screen_cycles);
		check_count("cycles in other colours", n_other, 0);
		fill_screen(8'h00, 8'h2b);
		wait_int_fall();
		measure_colours(paper_colour, black, n_screen, n_border, n_zero, n_other);
		check_count("paper cycles", n_screen, screen_cycles);
		check_count("cycles in other colours", n_other, 0);
	endtask

	task automatic test_port_fe();
		int n_screen;
		int n_border;
		int n_zero;
		int n_other;
		logic [7:0] data;
		// beeper and tape on, border 6
		io_write(16'h00fe, 8'h1e);
		@(posedge clk7);
		check_bit("beeper", beeper, 1'b1);
		check_bit("tape_out", tape_out, 1'b1);
		io_write(16'h00fe, 8'h06);
		@(posedge clk7);
		check_bit("beeper", beeper, 1'b0);
		check_bit("tape_out", tape_out, 1'b0);
		measure_colours(paper_colour, border_6, n_screen, n_border, n_zero, n_other);
		check_count("paper cycles", n_screen, screen_cycles);
		check_count("cycles in other colours", n_other, 0);
		if (n_border == 0 || n_zero == 0) begin
			report_fault("border or blank cycles missing from the frame");
		end
		@(posedge clk7);
		kd <= 5'h15;
		tape_in <= 1'b1;
		io_read(16'h00fe, data);
		check_byte("port fe read", data, {1'b1, 1'b1, 1'b1, 5'h15});
		// stored tape bit is 0, so the output follows tape_in
		check_bit("tape_out", tape_out, 1'b1);
		@(posedge clk7);
		kd <= 5'h0a;
		tape_in <= 1'b0;
		io_read(16'hfefe, data);
		check_byte("port fe read", data, {1'b1, 1'b0, 1'b1, 5'h0a});
	endtask

	task automatic test_paging();
		logic [18:0] va_seen;
		logic n_romcs_seen;
		logic n_vrd_seen;
		logic n_vwr_seen;
		// rom bank 1, ram bank 3
		io_write(16'h7ffd, 8'h13);
		mem_access(16'hc000, 1'b0, va_seen, n_romcs_seen, n_vrd_seen, n_vwr_seen);
		check_addr("va for #c000", va_seen, bank_va(3'd3, 16'hc000));
		check_bit("n_vrd", n_vrd_seen, 1'b0);
		check_bit("n_vwr", n_vwr_seen, 1'b1);
		check_bit("n_romcs", n_romcs_seen, 1'b1);
		mem_access(16'hc000, 1'b1, va_seen, n_romcs_seen, n_vrd_seen, n_vwr_seen);
		check_addr("va for #c000 write", va_seen, bank_va(3'd3, 16'hc000));
		check_bit("n_vrd on write", n_vrd_seen, 1'b1);
		check_bit("n_vwr on write", n_vwr_seen, 1'b0);
		mem_access(16'h4000, 1'b0, va_seen, n_romcs_seen, n_vrd_seen, n_vwr_seen);
		check_addr("va for #4000", va_seen, bank_va(3'd5, 16'h4000));
		mem_access(16'h0000, 1'b0, va_seen, n_romcs_seen, n_vrd_seen, n_vwr_seen);
		check_bit("n_romcs", n_romcs_seen, 1'b0);
		check_byte("ra", {5'b00000, ra}, 8'h01);
		// lock, then try to move to ram bank 6 and rom bank 0
		io_write(16'h7ffd, 8'h33);
		io_write(16'h7ffd, 8'h06);
		mem_access(16'hc000, 1'b0, va_seen, n_romcs_seen, n_vrd_seen, n_vwr_seen);
		check_addr("va for #c000 after lock", va_seen, bank_va(3'd3, 16'hc000));
		check_byte("ra after lock", {5'b00000, ra}, 8'h01);
	endtask

	initial begin
		#(watchdog_time);
		report_fault("watchdog timeout, the tests did not finish in time");
		print_counts();
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 93161;
		rst_n <= 1'b0;
		mode <= mode_128;
		cpu <= bus_cycle(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1);
		cpu_wdata <= '0;
		kd <= 5'h1f;
		tape_in <= 1'b0;
		fill_ram_random();
		repeat (2) @(posedge clk7);
		check_rgbi("rgbi in reset", rgbi, black);
		check_bit("n_int in reset", n_int, 1'b1);
		check_bit("n_romcs in reset", n_romcs, 1'b1);
		rst_n <= 1'b1;
		test_timing(mode_128);
		test_timing(mode_pent);
		test_screen_pixels();
		test_port_fe();
		test_paging();
		print_counts();
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- all.f
zx_pkg.sv
raster_timing.sv
screen_fetch.sv
io_ports.sv
mem_map.sv
zx_ula.sv
tb_zx_ula.sv

//--- Makefile
TOP := tb_zx_ula

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
